//--- run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module muldiv_tb \
	-f vlog.f -o muldiv_sim

./obj_dir/muldiv_sim 2>&1 | tee sim.log

# the log decides pass or fail
if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- src/muldiv_collect.sv
`timescale 1ns/10ps

module muldiv_collect #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  logic            in_valid,
	output logic            in_ready,
	input  muldiv_pkg::op_t in_op,
	input  muldiv_pkg::id_t in_id,
	input  logic [XLEN-1:0] in_a,
	input  logic [XLEN-1:0] in_b,
	output logic            out_valid,
	input  logic            out_ready,
	output muldiv_pkg::id_t out_id,
	output logic [XLEN-1:0] out_data,
	output logic            mul_start,
	output muldiv_pkg::op_t mul_op,
	output logic [XLEN-1:0] mul_a,
	output logic [XLEN-1:0] mul_b,
	input  logic            mul_done,
	input  logic [XLEN-1:0] mul_result,
	output logic            div_start,
	output muldiv_pkg::op_t div_op,
	output logic [XLEN-1:0] div_a,
	output logic [XLEN-1:0] div_b,
	input  logic            div_done,
	input  logic [XLEN-1:0] div_result
);

	import muldiv_pkg::*;

	typedef logic [XLEN-1:0] word_t;

	// per unit: busy, held id, result slot
	logic  mul_busy;
	logic  div_busy;
	logic  mul_full;
	logic  div_full;
	id_t   mul_id;
	id_t   div_id;
	word_t mul_slot;
	word_t div_slot;
	// mul slot filled before div slot
	logic  mul_older;

	// request held for the start pulse
	op_t   req_op;
	word_t req_a;
	word_t req_b;

	// ************************************************************************
	// request side
	// ************************************************************************

	logic in_div;
	logic acc_mul;
	logic acc_div;

	assign in_div   = in_op[2];
	assign in_ready = ~flush & (in_div ? (~div_busy & ~div_full) : (~mul_busy & ~mul_full));
	assign acc_mul  = in_valid & in_ready & ~in_div;
	assign acc_div  = in_valid & in_ready & in_div;

	assign mul_op = req_op;
	assign mul_a  = req_a;
	assign mul_b  = req_b;
	assign div_op = req_op;
	assign div_a  = req_a;
	assign div_b  = req_b;

	always_ff @(posedge clk) begin
		if (acc_mul | acc_div) begin
			req_op <= in_op;
			req_a  <= in_a;
			req_b  <= in_b;
		end
		if (acc_mul)
			mul_id <= in_id;
		if (acc_div)
			div_id <= in_id;
	end

	// ************************************************************************
	// result side, fresh done bypasses the slot
	// ************************************************************************

	logic  mul_pend;
	logic  div_pend;
	word_t mul_word;
	word_t div_word;
	logic  pick_mul;
	logic  out_load;
	logic  mul_take;
	logic  div_take;
	logic  mul_cap;
	logic  div_cap;

	assign mul_pend = mul_full | mul_done;
	assign div_pend = div_full | div_done;
	assign mul_word = mul_full ? mul_slot : mul_result;
	assign div_word = div_full ? div_slot : div_result;

	// oldest first, a held slot beats a fresh done, tie goes to mul
	assign pick_mul = mul_pend & (~div_pend | ((mul_full & div_full) ? mul_older : ~div_full));
	assign out_load = (mul_pend | div_pend) & (~out_valid | out_ready);
	assign mul_take = out_load & pick_mul;
	assign div_take = out_load & ~pick_mul;
	assign mul_cap  = mul_done & ~mul_take;
	assign div_cap  = div_done & ~div_take;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mul_start <= 1'b0;
			div_start <= 1'b0;
			mul_busy  <= 1'b0;
			div_busy  <= 1'b0;
			mul_full  <= 1'b0;
			div_full  <= 1'b0;
			mul_older <= 1'b0;
			out_valid <= 1'b0;
		end else if (flush) begin
			mul_start <= 1'b0;
			div_start <= 1'b0;
			mul_busy  <= 1'b0;
			div_busy  <= 1'b0;
			mul_full  <= 1'b0;
			div_full  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			mul_start <= acc_mul;
			div_start <= acc_div;
			// busy from acceptance to done
			if (acc_mul)
				mul_busy <= 1'b1;
			else if (mul_done)
				mul_busy <= 1'b0;
			if (acc_div)
				div_busy <= 1'b1;
			else if (div_done)
				div_busy <= 1'b0;
			if (mul_cap)
				mul_full <= 1'b1;
			else if (mul_take)
				mul_full <= 1'b0;
			if (div_cap)
				div_full <= 1'b1;
			else if (div_take)
				div_full <= 1'b0;
			// age order only matters while both slots hold
			if (mul_cap & div_cap)
				mul_older <= 1'b1;
			else if (mul_cap)
				mul_older <= ~(div_full & ~div_take);
			else if (div_cap)
				mul_older <= mul_full & ~mul_take;
			if (out_load)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_cap)
			mul_slot <= mul_result;
		if (div_cap)
			div_slot <= div_result;
		if (out_load) begin
			out_id   <= pick_mul ? mul_id : div_id;
			out_data <= pick_mul ? mul_word : div_word;
		end
	end

endmodule

//--- src/muldiv_div.sv
`timescale 1ns/10ps

module muldiv_div #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  logic            start,
	input  muldiv_pkg::op_t op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic            done,
	output logic [XLEN-1:0] result
);

	import muldiv_pkg::*;

	localparam int CNT_W = $clog2(XLEN);

	typedef logic [XLEN-1:0]  word_t;
	typedef logic [XLEN:0]    wide_t;
	typedef logic [CNT_W-1:0] cnt_t;

	div_state_t state;
	cnt_t       cnt;

	word_t rem;
	word_t quo;
	word_t dsor;
	word_t res;
	logic  q_neg;
	logic  r_neg;
	logic  div0;
	logic  ovf;
	logic  sel_rem;

	// operand decode
	logic  is_signed;
	logic  a_neg;
	logic  b_neg;
	word_t abs_a;
	word_t abs_b;

	assign is_signed = (op == OP_DIV) || (op == OP_REM);
	assign a_neg     = is_signed & a[XLEN-1];
	assign b_neg     = is_signed & b[XLEN-1];
	assign abs_a     = a_neg ? -a : a;
	assign abs_b     = b_neg ? -b : b;

	// ************************************************************************
	// one restoring step, first one taken straight from the operands
	// ************************************************************************

	word_t cur_rem;
	word_t cur_quo;
	word_t cur_dsor;
	wide_t shifted;
	wide_t diff;
	logic  fits;
	word_t step_rem;
	word_t step_quo;

	assign cur_rem  = (state == DIV_IDLE) ? '0 : rem;
	assign cur_quo  = (state == DIV_IDLE) ? abs_a : quo;
	assign cur_dsor = (state == DIV_IDLE) ? abs_b : dsor;

	// next dividend bit into the partial remainder
	assign shifted  = {cur_rem, cur_quo[XLEN-1]};
	assign diff     = shifted - {1'b0, cur_dsor};
	assign fits     = ~diff[XLEN];
	assign step_rem = fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
	assign step_quo = {cur_quo[XLEN-2:0], fits};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DIV_IDLE;
			cnt   <= '0;
		end else if (flush) begin
			state <= DIV_IDLE;
		end else begin
			case (state)
				DIV_IDLE: begin
					// first quotient bit done on the start edge
					if (start) begin
						state <= DIV_RUN;
						cnt   <= cnt_t'(1);
					end
				end
				DIV_RUN: begin
					cnt <= cnt + cnt_t'(1);
					if (cnt == cnt_t'(XLEN - 1))
						state <= DIV_FIX;
				end
				DIV_FIX:  state <= DIV_DONE;
				default:  state <= DIV_IDLE;
			endcase
		end
	end

	// sign fix-up and RISC-V special cases
	word_t q_fix;
	word_t r_fix;
	word_t q_out;
	word_t r_out;

	assign q_fix = q_neg ? -quo : quo;
	assign r_fix = r_neg ? -rem : rem;

	always_comb begin
		if (div0) begin
			// remainder already holds the dividend after XLEN steps
			q_out = '1;
			r_out = r_fix;
		end else if (ovf) begin
			q_out = {1'b1, {(XLEN-1){1'b0}}};
			r_out = '0;
		end else begin
			q_out = q_fix;
			r_out = r_fix;
		end
	end

	always_ff @(posedge clk) begin
		if (state == DIV_IDLE && start) begin
			rem     <= step_rem;
			quo     <= step_quo;
			dsor    <= abs_b;
			q_neg   <= a_neg ^ b_neg;
			r_neg   <= a_neg;
			div0    <= (b == '0);
			ovf     <= is_signed && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
			sel_rem <= (op == OP_REM) || (op == OP_REMU);
		end else if (state == DIV_RUN) begin
			rem <= step_rem;
			quo <= step_quo;
		end else if (state == DIV_FIX) begin
			res <= sel_rem ? r_out : q_out;
		end
	end

	assign done   = (state == DIV_DONE);
	assign result = res;

endmodule

//--- src/muldiv_mul.sv
`timescale 1ns/10ps

module muldiv_mul #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  logic            start,
	input  muldiv_pkg::op_t op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic            done,
	output logic [XLEN-1:0] result
);

	import muldiv_pkg::*;

	localparam int CNT_W = $clog2(XLEN);

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [2*XLEN-1:0] dword_t;
	typedef logic [CNT_W-1:0]  cnt_t;

	mul_state_t state;
	cnt_t       cnt;

	dword_t mcand;
	dword_t acc;
	dword_t prod;
	word_t  mplier;
	word_t  abs_a;
	word_t  abs_b;
	logic   neg;
	logic   low_half;

	// signedness of {a, b}
	logic [1:0] sgn;
	logic       a_neg;
	logic       b_neg;

	always_comb begin
		case (op)
			OP_MUL, OP_MULH: sgn = 2'b11;
			// only rs1 signed
			OP_MULHSU:       sgn = 2'b10;
			default:         sgn = 2'b00;
		endcase
	end

	assign a_neg = sgn[1] & a[XLEN-1];
	assign b_neg = sgn[0] & b[XLEN-1];
	// most negative value maps onto its own magnitude, still correct unsigned
	assign abs_a = a_neg ? -a : a;
	assign abs_b = b_neg ? -b : b;

	// ************************************************************************
	// control
	// ************************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MUL_IDLE;
			cnt   <= '0;
		end else if (flush) begin
			state <= MUL_IDLE;
		end else begin
			case (state)
				MUL_IDLE: begin
					if (start) begin
						state <= MUL_RUN;
						cnt   <= '0;
					end
				end
				MUL_RUN: begin
					cnt <= cnt + cnt_t'(1);
					// last of XLEN iterations
					if (cnt == cnt_t'(XLEN - 1))
						state <= MUL_DONE;
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	// shift-add datapath
	always_ff @(posedge clk) begin
		if (state == MUL_IDLE && start) begin
			mcand    <= dword_t'(abs_a);
			mplier   <= abs_b;
			acc      <= '0;
			neg      <= a_neg ^ b_neg;
			low_half <= (op == OP_MUL);
		end else if (state == MUL_RUN) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// fix-up cycle: restore sign, pick half
	assign prod   = neg ? -acc : acc;
	assign done   = (state == MUL_DONE);
	assign result = low_half ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];

endmodule

//--- src/muldiv_pkg.sv
package muldiv_pkg;

	// ************************************************************************
	// operation codes, funct3 of the M extension
	// ************************************************************************

	// bit 2 set selects the divider
	typedef logic [2:0] op_t;

	localparam op_t OP_MUL    = 3'b000;
	localparam op_t OP_MULH   = 3'b001;
	localparam op_t OP_MULHSU = 3'b010;
	localparam op_t OP_MULHU  = 3'b011;
	localparam op_t OP_DIV    = 3'b100;
	localparam op_t OP_DIVU   = 3'b101;
	localparam op_t OP_REM    = 3'b110;
	localparam op_t OP_REMU   = 3'b111;

	// request tag, echoed with the result
	typedef logic [3:0] id_t;

	// ************************************************************************
	// unit state machines
	// ************************************************************************

	// multiplier: done state is also the fix-up cycle
	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_DONE
	} mul_state_t;

	// divider: sign fix-up registered before done
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIX,
		DIV_DONE
	} div_state_t;

endpackage

//--- src/muldiv_unit.sv
`timescale 1ns/10ps

module muldiv_unit #(
	parameter int XLEN = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  logic            in_valid,
	output logic            in_ready,
	input  muldiv_pkg::op_t in_op,
	input  muldiv_pkg::id_t in_id,
	input  logic [XLEN-1:0] in_a,
	input  logic [XLEN-1:0] in_b,
	output logic            out_valid,
	input  logic            out_ready,
	output muldiv_pkg::id_t out_id,
	output logic [XLEN-1:0] out_data
);

	import muldiv_pkg::*;

	typedef logic [XLEN-1:0] word_t;

	// ************************************************************************
	// collector to multiplier
	// ************************************************************************

	logic  mul_start;
	op_t   mul_op;
	word_t mul_a;
	word_t mul_b;
	logic  mul_done;
	word_t mul_result;

	// collector to divider
	logic  div_start;
	op_t   div_op;
	word_t div_a;
	word_t div_b;
	logic  div_done;
	word_t div_result;

	muldiv_collect #(.XLEN(XLEN)) u_collect (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_id      (in_id),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_id     (out_id),
		.out_data   (out_data),
		.mul_start  (mul_start),
		.mul_op     (mul_op),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.div_start  (div_start),
		.div_op     (div_op),
		.div_a      (div_a),
		.div_b      (div_b),
		.div_done   (div_done),
		.div_result (div_result)
	);

	// both units run side by side
	muldiv_mul #(.XLEN(XLEN)) u_mul (
		.clk    (clk),
		.rst_n  (rst_n),
		.flush  (flush),
		.start  (mul_start),
		.op     (mul_op),
		.a      (mul_a),
		.b      (mul_b),
		.done   (mul_done),
		.result (mul_result)
	);

	muldiv_div #(.XLEN(XLEN)) u_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.flush  (flush),
		.start  (div_start),
		.op     (div_op),
		.a      (div_a),
		.b      (div_b),
		.done   (div_done),
		.result (div_result)
	);

endmodule

//--- tests/muldiv_sva.sv
`timescale 1ns/10ps

module muldiv_sva #(
	parameter int XLEN = 64
) (
	input logic            clk,
	input logic            rst_n,
	input logic            flush,
	input logic            in_ready,
	input logic            out_valid,
	input logic            out_ready,
	input muldiv_pkg::id_t out_id,
	input logic [XLEN-1:0] out_data
);

	// ************************************************************************
	// result handshake
	// ************************************************************************

	// stalled result holds its id and data
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready && !flush |=> $stable(out_data) && $stable(out_id))
		else $error("out_data or out_id changed under back-pressure");

	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !out_valid)
		else $error("out_valid still high after flush");

	// reset state
	reset_out: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> in_ready && !out_valid)
		else $error("unit not idle after reset");

endmodule

bind muldiv_unit muldiv_sva #(.XLEN(XLEN)) u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.flush     (flush),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_id    (out_id),
	.out_data  (out_data)
);

//--- tests/muldiv_tb.sv
`timescale 1ns/10ps

module muldiv_tb;

	import muldiv_pkg::*;

	localparam int XLEN = 64;
	localparam int TMO  = 4 * XLEN;
	localparam logic [31:0] SEED = 32'h33eeed4e;

	typedef logic [XLEN-1:0] word_t;

	localparam word_t MIN  = {1'b1, {(XLEN-1){1'b0}}};
	localparam word_t ONES = '1;
	// -20, -3 and -2
	localparam word_t M20  = 64'hffff_ffff_ffff_ffec;
	localparam word_t M3   = 64'hffff_ffff_ffff_fffd;
	localparam word_t M2   = 64'hffff_ffff_ffff_fffe;

	// ************************************************************************
	// directed table of op, a, b and expected result
	// ************************************************************************

	typedef struct packed {
		op_t   op;
		word_t a;
		word_t b;
		word_t res;
	} vec_t;

	localparam int NVEC = 26;

	localparam vec_t VECS [NVEC] = '{
		'{OP_MUL,    64'd3,  64'd5,  64'd15},
		'{OP_MUL,    ONES,   ONES,   64'd1},
		'{OP_MUL,    MIN,    ONES,   MIN},
		'{OP_MUL,    64'd0,  ONES,   64'd0},
		'{OP_MULH,   ONES,   ONES,   64'd0},
		'{OP_MULH,   MIN,    MIN,    64'h4000_0000_0000_0000},
		'{OP_MULH,   MIN,    64'd1,  ONES},
		'{OP_MULHU,  ONES,   ONES,   M2},
		'{OP_MULHU,  MIN,    64'd2,  64'd1},
		// mixed signs with only a signed
		'{OP_MULHSU, ONES,   64'd2,  ONES},
		'{OP_MULHSU, 64'd1,  ONES,   64'd0},
		'{OP_MULHSU, MIN,    ONES,   MIN},
		'{OP_DIV,    64'd20, 64'd6,  64'd3},
		'{OP_DIV,    M20,    64'd6,  M3},
		'{OP_REM,    M20,    64'd6,  M2},
		'{OP_DIVU,   64'd20, 64'd6,  64'd3},
		'{OP_REMU,   64'd20, 64'd6,  64'd2},
		// divide by zero
		'{OP_DIV,    64'd7,  64'd0,  ONES},
		'{OP_DIVU,   64'd7,  64'd0,  ONES},
		'{OP_REM,    M20,    64'd0,  M20},
		'{OP_REMU,   64'd7,  64'd0,  64'd7},
		// signed overflow next to the ordinary unsigned forms
		'{OP_DIV,    MIN,    ONES,   MIN},
		'{OP_REM,    MIN,    ONES,   64'd0},
		'{OP_DIVU,   MIN,    ONES,   64'd0},
		'{OP_REMU,   MIN,    ONES,   MIN},
		'{OP_DIV,    64'd0,  64'd5,  64'd0}
	};

	logic  clk;
	logic  rst_n;
	logic  flush;
	logic  in_valid;
	logic  in_ready;
	op_t   in_op;
	id_t   in_id;
	word_t in_a;
	word_t in_b;
	logic  out_valid;
	logic  out_ready;
	id_t   out_id;
	word_t out_data;

	// scoreboard by id
	// an id is outstanding while its two toggles differ
	word_t       exp_data [16];
	logic [15:0] sent_tgl;
	logic [15:0] recv_tgl;
	id_t         next_id;

	logic [31:0] lfsr;
	logic [31:0] bp_lfsr;
	// 0 always ready, 1 random, 2 held low
	logic [1:0]  ready_mode;

	int    i;
	int    n;
	id_t   fl_id;
	word_t r_op;
	word_t r_a;
	word_t r_b;
	word_t r_mode;

	muldiv_unit #(.XLEN(XLEN)) u_muldiv_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_op     (in_op),
		.in_id     (in_id),
		.in_a      (in_a),
		.in_b      (in_b),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_id    (out_id),
		.out_data  (out_data)
	);

	always #50 clk = ~clk;

	// galois step with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int nbits, output word_t v);
		int k;
		v = '0;
		for (k = 0; k < nbits; k++) begin
			v = {v[XLEN-2:0], lfsr[0]};
			lfsr = next_lfsr(lfsr);
		end
	endtask

	// ************************************************************************
	// reference model from the M extension rules
	// ************************************************************************

	function automatic word_t model(input op_t op, input word_t a, input word_t b);
		logic signed [2*XLEN-1:0] p_ss;
		logic signed [2*XLEN-1:0] p_su;
		logic [2*XLEN-1:0]        p_uu;
		logic signed [XLEN-1:0]   sq;
		logic signed [XLEN-1:0]   sr;
		word_t                    uq;
		word_t                    ur;
		logic                     div0;
		logic                     ovf;
		p_ss = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
		p_su = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{1'b0}}, b});
		p_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
		div0 = (b == '0);
		ovf  = (a == MIN) && (b == ONES);
		sq = '0;
		sr = '0;
		uq = '0;
		ur = '0;
		// quotients only where defined
		if (!div0) begin
			uq = a / b;
			ur = a % b;
			if (!ovf) begin
				sq = $signed(a) / $signed(b);
				sr = $signed(a) % $signed(b);
			end
		end
		case (op)
			OP_MUL:    return p_uu[XLEN-1:0];
			OP_MULH:   return p_ss[2*XLEN-1:XLEN];
			OP_MULHSU: return p_su[2*XLEN-1:XLEN];
			OP_MULHU:  return p_uu[2*XLEN-1:XLEN];
			OP_DIV:    return div0 ? ONES : (ovf ? MIN : word_t'(sq));
			OP_DIVU:   return div0 ? ONES : uq;
			OP_REM:    return div0 ? a : (ovf ? '0 : word_t'(sr));
			default:   return div0 ? a : ur;
		endcase
	endfunction

	task automatic check_value(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout after %0d cycles: %s", TMO, what);
		$display("TESTBENCH FAILED");
		$fatal(1, "wait timed out");
	endtask

	// ************************************************************************
	// request driver, result monitor, back-pressure
	// ************************************************************************

	task automatic send_req(input op_t op, input word_t a, input word_t b, input word_t exp);
		int k;
		check_value(word_t'(sent_tgl[next_id] ^ recv_tgl[next_id]), '0, "request id in use");
		exp_data[next_id] = exp;
		sent_tgl[next_id] = ~sent_tgl[next_id];
		@(posedge clk);
		in_valid <= 1'b1;
		in_op    <= op;
		in_id    <= next_id;
		in_a     <= a;
		in_b     <= b;
		k = 0;
		@(negedge clk);
		while (!in_ready) begin
			k++;
			if (k > TMO)
				report_timeout("in_ready stayed low");
			@(negedge clk);
		end
		// transfer on this edge
		@(posedge clk);
		in_valid <= 1'b0;
		next_id = next_id + 4'd1;
	endtask

	task automatic wait_idle();
		int k;
		k = 0;
		while ((sent_tgl ^ recv_tgl) != 16'd0) begin
			k++;
			if (k > TMO)
				report_timeout("results still outstanding");
			@(negedge clk);
		end
	endtask

	task automatic wait_out_valid();
		int k;
		k = 0;
		while (!out_valid) begin
			k++;
			if (k > TMO)
				report_timeout("out_valid never rose");
			@(negedge clk);
		end
	endtask

	task automatic set_ready(input logic [1:0] mode);
		@(negedge clk);
		ready_mode = mode;
	endtask

	task automatic drive_ready();
		forever begin
			@(posedge clk);
			case (ready_mode)
				2'd0: out_ready <= 1'b1;
				2'd1: begin
					out_ready <= bp_lfsr[0];
					bp_lfsr = next_lfsr(bp_lfsr);
				end
				default: out_ready <= 1'b0;
			endcase
		end
	endtask

	// transfer seen at negedge completes on the next edge
	task automatic watch_results();
		forever begin
			@(negedge clk);
			if (rst_n && out_valid && out_ready) begin
				check_value(word_t'(sent_tgl[out_id] ^ recv_tgl[out_id]), word_t'(1),
					$sformatf("id %0d returned while not outstanding", out_id));
				check_value(out_data, exp_data[out_id], $sformatf("result for id %0d", out_id));
				recv_tgl[out_id] = ~recv_tgl[out_id];
			end
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		flush      = 1'b0;
		in_valid   = 1'b0;
		in_op      = OP_MUL;
		in_id      = '0;
		in_a       = '0;
		in_b       = '0;
		out_ready  = 1'b1;
		sent_tgl   = '0;
		recv_tgl   = '0;
		next_id    = '0;
		lfsr       = SEED;
		bp_lfsr    = SEED;
		ready_mode = 2'd0;
		fork
			drive_ready();
			watch_results();
		join_none
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// idle after reset
		@(negedge clk);
		check_value(word_t'(in_ready), word_t'(1), "in_ready after reset");
		check_value(word_t'(out_valid), '0, "out_valid after reset");

		for (i = 0; i < NVEC; i++)
			send_req(VECS[i].op, VECS[i].a, VECS[i].b, VECS[i].res);
		wait_idle();

		// overlapping random ops under random back-pressure
		set_ready(2'd1);
		for (i = 0; i < 200; i++) begin
			take_bits(3, r_op);
			take_bits(XLEN, r_a);
			take_bits(XLEN, r_b);
			take_bits(2, r_mode);
			// small divisors including zero
			if (r_mode[1:0] == 2'b00)
				r_b = r_b & word_t'(15);
			send_req(op_t'(r_op[2:0]), r_a, r_b, model(op_t'(r_op[2:0]), r_a, r_b));
		end
		wait_idle();

		// ********************************************************************
		// full mul slot holds in_ready low
		// ********************************************************************
		set_ready(2'd2);
		send_req(OP_MUL, 64'd6, 64'd7, 64'd42);
		wait_out_valid();
		send_req(OP_MULHU, ONES, ONES, M2);
		n = 0;
		while (!u_muldiv_unit.u_collect.mul_full) begin
			n++;
			if (n > TMO)
				report_timeout("mul result never reached its slot");
			@(negedge clk);
		end
		check_value(word_t'(in_ready), '0, "in_ready with mul slot full");
		set_ready(2'd0);
		wait_idle();

		// ********************************************************************
		// flush with a result held and both units mid-run
		// ********************************************************************
		set_ready(2'd2);
		fl_id = next_id;
		send_req(OP_MUL, 64'd9, 64'd9, 64'd81);
		wait_out_valid();
		send_req(OP_MUL, 64'd5, 64'd5, 64'd25);
		send_req(OP_DIV, 64'd100, 64'd7, 64'd14);
		repeat (10) @(posedge clk);
		flush <= 1'b1;
		// flushed ids never come back
		for (i = 0; i < 3; i++)
			sent_tgl[id_t'(fl_id + i)] = ~sent_tgl[id_t'(fl_id + i)];
		@(posedge clk);
		flush <= 1'b0;
		for (i = 0; i < XLEN + 8; i++) begin
			@(negedge clk);
			check_value(word_t'(out_valid), '0, "out_valid after flush");
		end
		set_ready(2'd0);
		send_req(OP_REMU, 64'd100, 64'd7, 64'd2);
		wait_idle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- vlog.f
src/muldiv_pkg.sv
src/muldiv_mul.sv
src/muldiv_div.sv
src/muldiv_collect.sv
src/muldiv_unit.sv
tests/muldiv_sva.sv
tests/muldiv_tb.sv
